// ==== Makefile ====
# Verilator flow for the slideshow control core

TOP := tb_slideshow_ctrl

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --timescale 1ns/100ps -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps -f compile.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "sim failed" sim.log; then echo "simulation FAILED"; exit 1; fi
	@grep -q "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== compile.f ====
+incdir+.
slideshow_pkg.sv
swipe_debounce.sv
gesture_decoder.sv
load_monitor.sv
image_selector.sv
frame_addr_gen.sv
slideshow_ctrl.sv
tb_slideshow_ctrl.sv

// ==== frame_addr_gen.sv ====
// ========================================
// frame address generator
// sdram read window per frame and the
// read reload strobe
// ========================================

`default_nettype none

`include "slideshow_params.svh"

module frame_addr_gen
	import slideshow_pkg::*;
(
	input  logic         CLOCK_33,
	input  logic         iRSTN,
	input  frame_evt_t   frame,
	input  img_idx_t     current_img,
	output addr_window_t rd_window,
	output logic         rd_load
);

	// first word of the selected image
	addr_t img_base;

	assign img_base = addr_t'(current_img) * `IMG_WORDS;

	// ========================================
	// read window and reload
	// ========================================

	always_ff @(posedge CLOCK_33 or negedge iRSTN) begin
		if (!iRSTN) begin
			// image 0 until the first frame ends
			rd_window.base <= '0;
			rd_window.max  <= `IMG_WORDS;
			rd_load        <= 1'b0;
		end else begin
			// only switch images between frames
			if (frame.end_frame) begin
				rd_window.base <= img_base;
				rd_window.max  <= img_base + `IMG_WORDS;
			end
			// flush the read side as the next frame starts
			rd_load <= frame.new_frame;
		end
	end

	// ========================================
	// checks
	// ========================================

	// the read window covers exactly one image without wrapping the address space
	a_win_size: assert property (
		@(posedge CLOCK_33) disable iff (!iRSTN)
		frame.end_frame |=>
			(({1'b0, rd_window.max} - {1'b0, rd_window.base}) == {1'b0, `IMG_WORDS})
	);

endmodule

`default_nettype wire

// ==== gesture_decoder.sv ====
// ========================================
// gesture decoder
// qualifies touch reports by gesture code
// and debounces east and west swipes
// ========================================

`default_nettype none

`include "slideshow_params.svh"

module gesture_decoder
	import slideshow_pkg::*;
(
	input  logic          CLOCK_33,
	input  logic          iRSTN,
	input  touch_report_t touch,
	output logic          swipe_e,
	output logic          swipe_w
);

	// raw matches, valid only with the ready strobe
	logic trig_e;
	logic trig_w;

	// ========================================
	// code compare
	// ========================================

	// no register here, the debouncer sees the strobe directly
	assign trig_e = touch.ready && (touch.gesture == `GEST_EAST);
	assign trig_w = touch.ready && (touch.gesture == `GEST_WEST);

	// ========================================
	// one debouncer per direction
	// ========================================

	// east swipe, steps back through the slides
	swipe_debounce u_east (
		.CLOCK_33 (CLOCK_33),
		.iRSTN    (iRSTN),
		.trigger  (trig_e),
		.pulse    (swipe_e)
	);

	// west swipe, steps forward
	swipe_debounce u_west (
		.CLOCK_33 (CLOCK_33),
		.iRSTN    (iRSTN),
		.trigger  (trig_w),
		.pulse    (swipe_w)
	);

endmodule

`default_nettype wire

// ==== image_selector.sv ====
// ========================================
// image selector
// current image index, stepped by swipes
// with wrap-around once loading is done
// ========================================

`default_nettype none

module image_selector
	import slideshow_pkg::*;
(
	input  logic       CLOCK_33,
	input  logic       iRSTN,
	input  logic       load_done,
	input  logic [7:0] img_count,
	input  logic       swipe_e,
	input  logic       swipe_w,
	output img_idx_t   current_img
);

	// index of the last loaded image
	img_idx_t last_img;

	assign last_img = img_count[4:0] - 5'd1;

	// ========================================
	// index update
	// ========================================

	always_ff @(posedge CLOCK_33 or negedge iRSTN) begin
		if (!iRSTN) begin
			current_img <= '0;
		end else if (load_done) begin
			// east has priority when both arrive together
			if (swipe_e) begin
				if (current_img == 5'd0) begin
					current_img <= last_img;
				end else begin
					current_img <= current_img - 5'd1;
				end
			end else if (swipe_w) begin
				// wrap back to the first image
				if (current_img == last_img) begin
					current_img <= '0;
				end else begin
					current_img <= current_img + 5'd1;
				end
			end
		end
	end

	// ========================================
	// checks
	// ========================================

	// never point past the loaded images while the slideshow runs
	a_idx_in_range: assert property (
		@(posedge CLOCK_33) disable iff (!iRSTN)
		load_done |-> ({3'b000, current_img} < img_count)
	);

endmodule

`default_nettype wire

// ==== load_monitor.sv ====
// ========================================
// load monitor
// pixel counter, write window table,
// load-complete flag and loading FSM
// ========================================

`default_nettype none

`include "slideshow_params.svh"

module load_monitor
	import slideshow_pkg::*;
(
	input  logic         CLOCK_33,
	input  logic         iRSTN,
	input  logic         pixel_strobe,
	input  logic [7:0]   img_count,
	input  logic [7:0]   draw_type,
	output addr_window_t wr_window,
	output logic         load_done,
	output logic         loading
);

	localparam int TAIL_W = $clog2(`LOAD_TAIL + 1);

	// loading FSM states
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_LOAD,
		ST_TAIL,
		ST_DONE
	} load_state_t;

	load_state_t       state;
	pix_count_t        pix_count;
	logic [TAIL_W-1:0] tail_cnt;
	// words in the write window
	addr_t             win_span;

	// ========================================
	// write window table
	// ========================================

	// unknown draw types fall back to full background
	always_comb begin
		case (draw_type)
			8'h01:   wr_window = '{base: `WIN1_BASE, max: `WIN1_MAX};
			8'h02:   wr_window = '{base: `WIN2_BASE, max: `WIN2_MAX};
			default: wr_window = '{base: `WIN0_BASE, max: `WIN0_MAX};
		endcase
	end

	// ========================================
	// pixel count and completion
	// ========================================

	always_ff @(posedge CLOCK_33 or negedge iRSTN) begin
		if (!iRSTN) begin
			pix_count <= '0;
		end else if (pixel_strobe) begin
			pix_count <= pix_count + 1'b1;
		end
	end

	// two words per pixel, so half the span in pixels
	assign win_span  = wr_window.max - wr_window.base;
	assign load_done = (img_count != 8'd0) && (pix_count == pix_count_t'(win_span >> 1));

	// ========================================
	// loading FSM with tail counter
	// ========================================

	always_ff @(posedge CLOCK_33 or negedge iRSTN) begin
		if (!iRSTN) begin
			state    <= ST_IDLE;
			tail_cnt <= '0;
		end else begin
			case (state)
				// first pixel seen, images are arriving
				ST_IDLE: if (pix_count != '0) state <= ST_LOAD;
				ST_LOAD: begin
					tail_cnt <= '0;
					if (load_done) state <= ST_TAIL;
				end
				// keep loading up a little while the last writes drain
				ST_TAIL: begin
					if (tail_cnt == TAIL_W'(`LOAD_TAIL - 1)) begin
						state <= ST_DONE;
					end else begin
						tail_cnt <= tail_cnt + 1'b1;
					end
				end
				// stays here until the next reset
				default: state <= ST_DONE;
			endcase
		end
	end

	assign loading = (state == ST_LOAD) || (state == ST_TAIL);

endmodule

`default_nettype wire

// ==== slideshow_ctrl.sv ====
// ========================================
// slideshow control core, top level
// load monitor, gesture decoder, image
// selector and frame address generator
// ========================================

`default_nettype none

module slideshow_ctrl
	import slideshow_pkg::*;
(
	input  logic          CLOCK_33,
	input  logic          iRSTN,
	input  logic          pixel_strobe,
	input  logic [7:0]    img_count,
	input  logic [7:0]    draw_type,
	input  touch_report_t touch,
	input  frame_evt_t    frame,
	output addr_window_t  wr_window,
	output logic          loading,
	output logic          load_done,
	output img_idx_t      current_img,
	output addr_window_t  rd_window,
	output logic          rd_load
);

	// debounced swipe pulses
	logic swipe_e;
	logic swipe_w;

	// ========================================
	// write side
	// ========================================

	// counts pixels from the host and tracks image loading
	load_monitor u_load_monitor (
		.CLOCK_33     (CLOCK_33),
		.iRSTN        (iRSTN),
		.pixel_strobe (pixel_strobe),
		.img_count    (img_count),
		.draw_type    (draw_type),
		.wr_window    (wr_window),
		.load_done    (load_done),
		.loading      (loading)
	);

	// ========================================
	// touch and image selection
	// ========================================

	gesture_decoder u_gesture_decoder (
		.CLOCK_33 (CLOCK_33),
		.iRSTN    (iRSTN),
		.touch    (touch),
		.swipe_e  (swipe_e),
		.swipe_w  (swipe_w)
	);

	// swipes only take effect once every image is in
	image_selector u_image_selector (
		.CLOCK_33    (CLOCK_33),
		.iRSTN       (iRSTN),
		.load_done   (load_done),
		.img_count   (img_count),
		.swipe_e     (swipe_e),
		.swipe_w     (swipe_w),
		.current_img (current_img)
	);

	// ========================================
	// read side
	// ========================================

	frame_addr_gen u_frame_addr_gen (
		.CLOCK_33    (CLOCK_33),
		.iRSTN       (iRSTN),
		.frame       (frame),
		.current_img (current_img),
		.rd_window   (rd_window),
		.rd_load     (rd_load)
	);

endmodule

`default_nettype wire

// ==== slideshow_params.svh ====
// ========================================
// global defines for the slideshow core
// image size, write window table, swipe
// debounce delays, loading tail, gestures
// ========================================

`ifndef SLIDESHOW_PARAMS_SVH
`define SLIDESHOW_PARAMS_SVH

// sdram words per 800x480 image, two 16-bit words per pixel
`define IMG_WORDS      24'd768000

// write windows, one per draw type
`define WIN0_BASE      24'd0
`define WIN0_MAX       24'd768000
`define WIN1_BASE      24'd500
`define WIN1_MAX       24'd65000
`define WIN2_BASE      24'd76800
`define WIN2_MAX       24'd768000

// swipe debounce, shortened for simulation
`define SWIPE_DELAY    20
`define SWIPE_HOLDOFF  50

// cycles loading stays up after the window is full
`define LOAD_TAIL      50

// touch controller gesture codes
`define GEST_EAST      8'h14
`define GEST_WEST      8'h1C

`endif

// ==== slideshow_pkg.sv ====
// ========================================
// shared types of the slideshow core
// addresses, image index, pixel count,
// address windows, touch and frame events
// ========================================

`default_nettype none

package slideshow_pkg;

	// ========================================
	// scalar types
	// ========================================

	// sdram word address, 16-bit words
	typedef logic [23:0] addr_t;

	// index of the image on screen, up to 32 images
	typedef logic [4:0] img_idx_t;

	// number of pixels received from the host
	typedef logic [31:0] pix_count_t;

	// ========================================
	// bundles
	// ========================================

	// sdram access window, base inclusive, max exclusive
	typedef struct packed {
		addr_t base;
		addr_t max;
	} addr_window_t;

	// one report from the touch controller
	// ready is a one-cycle strobe, gesture holds the code
	typedef struct packed {
		logic       ready;
		logic [7:0] gesture;
	} touch_report_t;

	// frame markers from the lcd timing side
	typedef struct packed {
		logic new_frame;
		logic end_frame;
	} frame_evt_t;

endpackage

`default_nettype wire

// ==== swipe_debounce.sv ====
// ========================================
// swipe debouncer
// one delayed pulse per trigger, then a
// hold-off before it can fire again
// ========================================

`default_nettype none

`include "slideshow_params.svh"

module swipe_debounce (
	input  logic CLOCK_33,
	input  logic iRSTN,
	input  logic trigger,
	output logic pulse
);

	// counter must reach the hold-off value
	localparam int CNT_W = $clog2(`SWIPE_HOLDOFF + 1);

	// high from the accepted trigger until the hold-off ends
	logic             active;
	// cycles since the trigger was accepted, minus one
	logic [CNT_W-1:0] count;

	// ========================================
	// active flag and hold-off counter
	// ========================================

	always_ff @(posedge CLOCK_33 or negedge iRSTN) begin
		if (!iRSTN) begin
			active <= 1'b0;
			count  <= '0;
		end else if (!active) begin
			// idle, arm on the next trigger
			count <= '0;
			if (trigger) begin
				active <= 1'b1;
			end
		end else if (count == CNT_W'(`SWIPE_HOLDOFF)) begin
			// hold-off over, re-arm
			active <= 1'b0;
			count  <= '0;
		end else begin
			// triggers are ignored while counting
			count <= count + 1'b1;
		end
	end

	// pulse once, SWIPE_DELAY+1 cycles after the trigger
	assign pulse = active && (count == CNT_W'(`SWIPE_DELAY));

	// ========================================
	// checks
	// ========================================

	// a single swipe never gives a double step
	a_single_pulse: assert property (
		@(posedge CLOCK_33) disable iff (!iRSTN)
		pulse |=> !pulse
	);

endmodule

`default_nettype wire

// ==== tb_slideshow_ctrl.sv ====
// ========================================
// testbench for the slideshow control core
// scenario table, swipe reference model,
// frame window checks and watchdog
// ========================================

`default_nettype none

`include "slideshow_params.svh"

module tb_slideshow_ctrl
	import slideshow_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD = 20;

	// swipe codes, bit 0 picks west, bit 1 repeats it inside the hold-off
	localparam logic [1:0] SW_E  = 2'b00;
	localparam logic [1:0] SW_W  = 2'b01;
	localparam logic [1:0] SW_ED = 2'b10;
	localparam logic [1:0] SW_WD = 2'b11;

	typedef logic [47:0] val_t;

	// one row per reset, swipes listed left to right in the order applied
	typedef struct packed {
		logic [7:0]  draw_type;
		logic [7:0]  img_count;
		logic [3:0]  n_swipes;
		logic [15:0] swipes;
		addr_t       exp_base;
		addr_t       exp_max;
	} scenario_t;

	localparam int N_SCEN = 4;

	// draw type, images, swipe count, swipe list, expected write window
	localparam scenario_t SCEN_TABLE [N_SCEN] = '{
		'{8'd0, 8'd4, 4'd4, {SW_W, SW_W, SW_ED, SW_E, SW_E, SW_E, SW_E, SW_E},
			24'd0, 24'd768000},
		'{8'd1, 8'd3, 4'd5, {SW_E, SW_W, SW_W, SW_WD, SW_W, SW_E, SW_E, SW_E},
			24'd500, 24'd65000},
		'{8'd2, 8'd2, 4'd3, {SW_W, SW_WD, SW_E, SW_E, SW_E, SW_E, SW_E, SW_E},
			24'd76800, 24'd768000},
		'{8'd7, 8'd5, 4'd4, {SW_E, SW_ED, SW_W, SW_W, SW_E, SW_E, SW_E, SW_E},
			24'd0, 24'd768000}
	};

	logic          CLOCK_33 = 1'b0;
	logic          iRSTN;
	logic          pixel_strobe;
	logic [7:0]    img_count;
	logic [7:0]    draw_type;
	touch_report_t touch;
	frame_evt_t    frame;
	addr_window_t  wr_window;
	logic          loading;
	logic          load_done;
	img_idx_t      current_img;
	addr_window_t  rd_window;
	logic          rd_load;

	int            err_count = 0;
	int            scen_idx  = 0;
	logic [31:0]   rng_state = 32'd93465;

	always #(CLK_PERIOD / 2) CLOCK_33 = ~CLOCK_33;

	slideshow_ctrl u_slideshow_ctrl (
		.CLOCK_33     (CLOCK_33),
		.iRSTN        (iRSTN),
		.pixel_strobe (pixel_strobe),
		.img_count    (img_count),
		.draw_type    (draw_type),
		.touch        (touch),
		.frame        (frame),
		.wr_window    (wr_window),
		.loading      (loading),
		.load_done    (load_done),
		.current_img  (current_img),
		.rd_window    (rd_window),
		.rd_load      (rd_load)
	);

	// ========================================
	// helpers
	// ========================================

	task automatic check_val(input string name, input val_t expected, input val_t actual);
		if (expected !== actual) begin
			err_count++;
			$display("ERR scen%0d %s expected %0d actual %0d", scen_idx, name, expected, actual);
			$display("sim failed");
			$fatal(1);
		end
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// pixels to fill a window, two sdram words each
	function automatic int half_span(input scenario_t s);
		return int'((s.exp_max - s.exp_base) >> 1);
	endfunction

	// expected index after one swipe, east steps back
	function automatic int next_img(input int cur, input int cnt, input logic west);
		if (west) begin
			return (cur == cnt - 1) ? 0 : cur + 1;
		end
		return (cur == 0) ? cnt - 1 : cur - 1;
	endfunction

	// one-cycle touch report, leaves the clock one edge later
	task automatic send_touch(input logic west);
		@(posedge CLOCK_33);
		touch <= '{ready: 1'b1, gesture: (west ? `GEST_WEST : `GEST_EAST)};
		@(posedge CLOCK_33);
		touch <= '{ready: 1'b0, gesture: 8'h00};
	endtask

	task automatic apply_reset(input scenario_t s);
		@(posedge CLOCK_33);
		iRSTN        <= 1'b0;
		pixel_strobe <= 1'b0;
		draw_type    <= s.draw_type;
		img_count    <= s.img_count;
		touch        <= '0;
		frame        <= '0;
		repeat (10) @(posedge CLOCK_33);
		iRSTN <= 1'b1;
		@(negedge CLOCK_33);
	endtask

	// end of frame, then new frame on the next cycle
	task automatic check_frame(input int ref_img);
		addr_t base;
		base = addr_t'(ref_img * 768000);
		@(posedge CLOCK_33);
		frame <= '{new_frame: 1'b0, end_frame: 1'b1};
		@(posedge CLOCK_33);
		frame <= '{new_frame: 1'b1, end_frame: 1'b0};
		@(negedge CLOCK_33);
		check_val("rd_base", val_t'(base), val_t'(rd_window.base));
		check_val("rd_max", val_t'(base + 24'd768000), val_t'(rd_window.max));
		check_val("rd_load_early", val_t'(0), val_t'(rd_load));
		@(posedge CLOCK_33);
		frame <= '0;
		@(negedge CLOCK_33);
		check_val("rd_load", val_t'(1), val_t'(rd_load));
		@(negedge CLOCK_33);
		check_val("rd_load_end", val_t'(0), val_t'(rd_load));
	endtask

	// ========================================
	// watchdog
	// ========================================

	initial begin : watchdog
		longint budget;
		budget = 0;
		// the pre-load swipe of each row counts as one more swipe
		for (int i = 0; i < N_SCEN; i++) begin
			budget += half_span(SCEN_TABLE[i]) + 200 * (SCEN_TABLE[i].n_swipes + 1);
		end
		#(budget * CLK_PERIOD);
		$display("run timed out after %0d cycles", budget);
		$display("sim failed");
		$fatal(1);
	end

	// ========================================
	// main sequence
	// ========================================

	initial begin : main
		scenario_t  sc;
		int         n_pix;
		int         ref_img;
		int         wait_cnt;
		int         gap;
		logic [1:0] code;

		iRSTN        <= 1'b0;
		pixel_strobe <= 1'b0;
		img_count    <= 8'd0;
		draw_type    <= 8'd0;
		touch        <= '0;
		frame        <= '0;

		for (int i = 0; i < N_SCEN; i++) begin
			scen_idx = i;
			sc       = SCEN_TABLE[i];
			n_pix    = half_span(sc);
			ref_img  = 0;
			apply_reset(sc);

			// state right out of reset
			check_val("wr_base", val_t'(sc.exp_base), val_t'(wr_window.base));
			check_val("wr_max", val_t'(sc.exp_max), val_t'(wr_window.max));
			check_val("rst_rd_base", val_t'(0), val_t'(rd_window.base));
			check_val("rst_rd_max", val_t'(768000), val_t'(rd_window.max));
			check_val("rst_img", val_t'(0), val_t'(current_img));
			check_val("rst_loading", val_t'(0), val_t'(loading));
			check_val("rst_rd_load", val_t'(0), val_t'(rd_load));

			// a swipe before loading is complete must not move the index
			send_touch(1'b1);
			repeat (`SWIPE_HOLDOFF + 2) @(posedge CLOCK_33);
			@(negedge CLOCK_33);
			check_val("early_swipe", val_t'(0), val_t'(current_img));

			// pixels back to back, one per cycle
			@(posedge CLOCK_33);
			pixel_strobe <= 1'b1;
			@(negedge CLOCK_33);
			check_val("loading_pre", val_t'(0), val_t'(loading));
			repeat (2) @(posedge CLOCK_33);
			@(negedge CLOCK_33);
			check_val("loading_rise", val_t'(1), val_t'(loading));
			repeat (n_pix - 3) @(posedge CLOCK_33);
			@(negedge CLOCK_33);
			check_val("load_done_early", val_t'(0), val_t'(load_done));
			@(posedge CLOCK_33);
			pixel_strobe <= 1'b0;
			@(negedge CLOCK_33);
			check_val("load_done", val_t'(1), val_t'(load_done));

			// loading drops after the tail
			wait_cnt = 0;
			while (loading && wait_cnt < `LOAD_TAIL + 4) begin
				@(negedge CLOCK_33);
				wait_cnt++;
			end
			check_val("loading_fall", val_t'(0), val_t'(loading));
			check_val("load_done_hold", val_t'(1), val_t'(load_done));

			for (int k = 0; k < sc.n_swipes; k++) begin
				code    = sc.swipes[15 - 2 * k -: 2];
				ref_img = next_img(ref_img, int'(sc.img_count), code[0]);
				send_touch(code[0]);
				repeat (`SWIPE_DELAY + 1) @(posedge CLOCK_33);
				@(negedge CLOCK_33);
				check_val("swipe_img", val_t'(ref_img), val_t'(current_img));
				// same direction again while the debouncer holds off
				if (code[1]) begin
					send_touch(code[0]);
					repeat (`SWIPE_DELAY + 1) @(posedge CLOCK_33);
					@(negedge CLOCK_33);
					check_val("repeat_img", val_t'(ref_img), val_t'(current_img));
				end
				rng_state = xorshift(rng_state);
				gap       = `SWIPE_HOLDOFF + 3 + int'(rng_state[4:0]);
				repeat (gap) @(posedge CLOCK_33);
				check_frame(ref_img);
			end
		end

		if (err_count == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
